// File: include/div_settings.svh
/* divider settings
   operand width and iteration counter width shared by the divider and its bench */

`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand width in bits, one iteration per bit
`define DIV_WIDTH 32

// iteration counter, wide enough to hold the last step index
`define DIV_CNT_WIDTH 6

`endif

// File: src/div_msg_pkg.sv
/* divider message package
   encodings carried in the request message of the divider */

package div_msg_pkg;

  // ------------------------------------------------------------
  // request function field
  // ------------------------------------------------------------

  // selects how both operands are interpreted
  typedef enum logic {
    // operands taken as plain unsigned values
    DIV_FN_UNSIGNED = 1'b0,
    // operands taken as two's complement values
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

endpackage

// File: src/div_ctrl_pkg.sv
/* divider control package
   state encoding of the divider control FSM */

package div_ctrl_pkg;

  // idle waits for a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

endpackage

// File: src/int_div_ctrl.sv
/* iterative divider control
   FSM that accepts a request, counts the shift-subtract steps and
   holds the response until the sink takes it */

`timescale 1ns/10ps
`include "div_settings.svh"

module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  input  logic resp_rdy,
  output logic resp_val,

  // datapath controls
  output logic load,
  output logic step
);

  // index of the final iteration, one step per operand bit
  localparam logic [`DIV_CNT_WIDTH-1:0] last_step = (`DIV_CNT_WIDTH)'(31);

  // ------------------------------------------------------------
  // state and counter
  // ------------------------------------------------------------

  div_ctrl_pkg::div_state_e state;
  div_ctrl_pkg::div_state_e state_next;

  logic [`DIV_CNT_WIDTH-1:0] count;

  // high on the edge that performs the last iteration
  logic calc_last;

  assign calc_last = step && (count == last_step);

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      div_ctrl_pkg::IDLE: begin
        // accept as soon as a request shows up
        if (req_val) begin
          state_next = div_ctrl_pkg::CALC;
        end
      end
      div_ctrl_pkg::CALC: begin
        if (calc_last) begin
          state_next = div_ctrl_pkg::DONE;
        end
      end
      div_ctrl_pkg::DONE: begin
        // leave only once the sink has taken the result
        if (resp_rdy) begin
          state_next = div_ctrl_pkg::IDLE;
        end
      end
      default: begin
        // unused encoding falls back to idle
        state_next = div_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_ctrl_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // counter restarts on accept and wraps after the last step
      if (load || calc_last) begin
        count <= '0;
      end else if (step) begin
        count <= count + (`DIV_CNT_WIDTH)'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // outputs decoded from the state
  // ------------------------------------------------------------

  assign req_rdy  = (state == div_ctrl_pkg::IDLE);
  assign resp_val = (state == div_ctrl_pkg::DONE);

  // load coincides with the accepting edge
  assign load = req_rdy && req_val;
  // one iteration on every cycle spent in calc
  assign step = (state == div_ctrl_pkg::CALC);

endmodule

// File: src/int_div_dpath.sv
/* iterative divider datapath
   operand capture, restoring shift-subtract step and sign fix-up
   of the quotient and remainder */

`timescale 1ns/10ps
`include "div_settings.svh"

module int_div_dpath (
  input  logic                      clk,
  input  logic                      reset,

  // request message
  input  div_msg_pkg::div_fn_e      req_fn,
  input  logic [`DIV_WIDTH-1:0]     req_a,
  input  logic [`DIV_WIDTH-1:0]     req_b,

  // controls from the FSM
  input  logic                      load,
  input  logic                      step,

  // remainder above quotient
  output logic [2*`DIV_WIDTH-1:0]   resp_result
);

  localparam int w = `DIV_WIDTH;

  // ------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------

  logic         req_signed;
  logic         a_neg;
  logic         b_neg;
  logic [w-1:0] a_mag;
  logic [w-1:0] b_mag;

  assign req_signed = (req_fn == div_msg_pkg::DIV_FN_SIGNED);

  // negative operands only exist in signed mode
  assign a_neg = req_signed && req_a[w-1];
  assign b_neg = req_signed && req_b[w-1];

  assign a_mag = a_neg ? (~req_a + w'(1)) : req_a;
  assign b_mag = b_neg ? (~req_b + w'(1)) : req_b;

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  div_msg_pkg::div_fn_e fn_reg;
  logic                 sign_a_reg;
  logic                 sign_b_reg;

  // upper half partial remainder, lower half dividend bits going
  // out on the left and quotient bits coming in on the right
  logic [2*w-1:0] rq_reg;
  logic [2*w-1:0] rq_next;
  logic [w-1:0]   divisor_reg;

  // function and signs steer the fix-up
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= div_msg_pkg::DIV_FN_UNSIGNED;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      fn_reg     <= req_fn;
      sign_a_reg <= req_a[w-1];
      sign_b_reg <= req_b[w-1];
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // remainder starts at zero, dividend magnitude sits low
      rq_reg      <= {{w{1'b0}}, a_mag};
      divisor_reg <= b_mag;
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  // ------------------------------------------------------------
  // one restoring iteration
  // ------------------------------------------------------------

  // shifted remainder needs one extra bit, the divisor may use the msb
  logic [w:0] trial;

  assign trial = rq_reg[2*w-1:w-1] - {1'b0, divisor_reg};

  // borrow out means the divisor did not fit, keep the shifted value
  assign rq_next = trial[w] ? {rq_reg[2*w-2:0], 1'b0}
                            : {trial[w-1:0], rq_reg[w-2:0], 1'b1};

  // ------------------------------------------------------------
  // sign fix-up
  // ------------------------------------------------------------

  logic         fn_signed;
  logic         neg_quo;
  logic         neg_rem;
  logic [w-1:0] quo_mag;
  logic [w-1:0] rem_mag;
  logic [w-1:0] quo_fixed;
  logic [w-1:0] rem_fixed;

  assign fn_signed = (fn_reg == div_msg_pkg::DIV_FN_SIGNED);

  assign quo_mag = rq_reg[w-1:0];
  assign rem_mag = rq_reg[2*w-1:w];

  // quotient negative when the operand signs differ
  assign neg_quo = fn_signed && (sign_a_reg ^ sign_b_reg);
  // remainder follows the dividend
  assign neg_rem = fn_signed && sign_a_reg;

  assign quo_fixed = neg_quo ? (~quo_mag + w'(1)) : quo_mag;
  assign rem_fixed = neg_rem ? (~rem_mag + w'(1)) : rem_mag;

  assign resp_result = {rem_fixed, quo_fixed};

endmodule

// File: src/int_div_iterative.sv
/* iterative integer divider
   request/response unit built from the control FSM and the datapath */

`timescale 1ns/10ps
`include "div_settings.svh"

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,

  // request port
  input  div_msg_pkg::div_fn_e      req_fn,
  input  logic [`DIV_WIDTH-1:0]     req_a,
  input  logic [`DIV_WIDTH-1:0]     req_b,
  input  logic                      req_val,
  output logic                      req_rdy,

  // response port
  output logic [2*`DIV_WIDTH-1:0]   resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // ------------------------------------------------------------
  // control to datapath
  // ------------------------------------------------------------

  // capture request and clear the iteration registers
  logic load;
  // one shift-subtract iteration
  logic step;

  int_div_ctrl u_int_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_rdy (resp_rdy),
    .resp_val (resp_val),
    .load     (load),
    .step     (step)
  );

  // result stays put in done since step is low there
  int_div_dpath u_int_div_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .resp_result (resp_result)
  );

endmodule

// File: bench/int_div_asserts.sv
/* divider control assertions
   handshake exclusivity, response hold and counter range */

`timescale 1ns/10ps
`include "div_settings.svh"

module int_div_asserts (
  input logic                      clk,
  input logic                      reset,
  input logic                      req_rdy,
  input logic                      resp_val,
  input logic                      resp_rdy,
  input div_ctrl_pkg::div_state_e  state,
  input logic [`DIV_CNT_WIDTH-1:0] count
);

  // idle and done never overlap
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val))
    else $error("req_rdy and resp_val are high together");

  // response held until the sink takes it
  assert property (@(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> resp_val)
    else $error("resp_val dropped without resp_rdy");

  // last step index is 31
  assert property (@(posedge clk) disable iff (reset) count <= (`DIV_CNT_WIDTH)'(31))
    else $error("iteration counter went past 31");

  // counter rests at zero whenever no iteration is running
  assert property (@(posedge clk) disable iff (reset)
                   (state != div_ctrl_pkg::CALC) |-> (count == '0))
    else $error("iteration counter not cleared outside the calc state");

endmodule

bind int_div_ctrl int_div_asserts u_int_div_asserts (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .state    (state),
  .count    (count)
);

// File: bench/int_div_tb.sv
/* iterative divider testbench
   table of requests checked against a restoring-division model,
   with latency, back-pressure and reset checks */

`timescale 1ns/10ps
`include "div_settings.svh"

module int_div_tb;

  localparam int w           = `DIV_WIDTH;
  localparam int max_entries = 24;
  localparam int num_random  = 8;

  logic                 clk;
  logic                 reset;
  div_msg_pkg::div_fn_e req_fn;
  logic [w-1:0]         req_a;
  logic [w-1:0]         req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [2*w-1:0]       resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int_div_iterative u_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------

  string                tab_name  [max_entries];
  div_msg_pkg::div_fn_e tab_fn    [max_entries];
  logic [w-1:0]         tab_a     [max_entries];
  logic [w-1:0]         tab_b     [max_entries];
  // cycles resp_rdy stays low once the result is up
  int                   tab_stall [max_entries];

  int   num_entries;
  int   max_stall;
  int   error_count;
  logic table_done;

  task automatic add_entry(input string name, input div_msg_pkg::div_fn_e fn,
                           input logic [w-1:0] a, input logic [w-1:0] b, input int stall);
    tab_name[num_entries]  = name;
    tab_fn[num_entries]    = fn;
    tab_a[num_entries]     = a;
    tab_b[num_entries]     = b;
    tab_stall[num_entries] = stall;
    if (stall > max_stall) begin
      max_stall = stall;
    end
    num_entries++;
  endtask

  // restoring division on magnitudes, then sign fix-up
  function automatic logic [2*w-1:0] compute_expected(input div_msg_pkg::div_fn_e fn,
                                                      input logic [w-1:0] a,
                                                      input logic [w-1:0] b);
    logic         sgn;
    logic [w-1:0] mag_a;
    logic [w-1:0] mag_b;
    logic [w-1:0] quo;
    logic [w:0]   rem;
    logic [w-1:0] rem_out;
    sgn   = (fn == div_msg_pkg::DIV_FN_SIGNED);
    mag_a = (sgn && a[w-1]) ? -a : a;
    mag_b = (sgn && b[w-1]) ? -b : b;
    rem   = '0;
    quo   = '0;
    for (int i = w - 1; i >= 0; i--) begin
      // bring in the next dividend bit, keep the difference if it fits
      rem = {rem[w-1:0], mag_a[i]};
      if (rem >= {1'b0, mag_b}) begin
        rem    = rem - {1'b0, mag_b};
        quo[i] = 1'b1;
      end
    end
    rem_out = rem[w-1:0];
    if (sgn && (a[w-1] ^ b[w-1])) begin
      quo = -quo;
    end
    if (sgn && a[w-1]) begin
      rem_out = -rem_out;
    end
    return {rem_out, quo};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------
  // one request through accept, iterations, stall and release
  // ------------------------------------------------------------

  task automatic run_entry(input int idx);
    logic [2*w-1:0] expected;
    logic [2*w-1:0] held;
    int             latency;
    expected = compute_expected(tab_fn[idx], tab_a[idx], tab_b[idx]);
    req_fn   = tab_fn[idx];
    req_a    = tab_a[idx];
    req_b    = tab_b[idx];
    req_val  = 1'b1;
    check_value({tab_name[idx], " ready"}, 64'd1, 64'(req_rdy));
    // accepting edge
    @(posedge clk);
    #2;
    req_val = 1'b0;
    latency = 0;
    while (!resp_val) begin
      check_value({tab_name[idx], " busy"}, 64'd0, 64'(req_rdy));
      @(posedge clk);
      #2;
      latency++;
    end
    check_value({tab_name[idx], " latency"}, 64'd32, 64'(latency));
    check_value(tab_name[idx], 64'(expected), 64'(resp_result));
    held = resp_result;
    // a second request offered while stalled must be ignored
    req_val = 1'b1;
    req_a   = $urandom();
    req_b   = $urandom();
    repeat (tab_stall[idx]) begin
      @(posedge clk);
      #2;
      check_value({tab_name[idx], " hold"}, 64'(held), 64'(resp_result));
      check_value({tab_name[idx], " stall valid"}, 64'd1, 64'(resp_val));
      check_value({tab_name[idx], " stall ready"}, 64'd0, 64'(req_rdy));
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    // response handshake edge
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
    check_value({tab_name[idx], " released"}, 64'd0, 64'(resp_val));
    check_value({tab_name[idx], " ready again"}, 64'd1, 64'(req_rdy));
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    logic [w-1:0] rnd;
    clk         = 1'b0;
    reset       = 1'b1;
    req_fn      = div_msg_pkg::DIV_FN_UNSIGNED;
    req_a       = '0;
    req_b       = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    num_entries = 0;
    max_stall   = 0;
    error_count = 0;
    table_done  = 1'b0;
    void'($urandom(23661));

    add_entry("unsigned basic", div_msg_pkg::DIV_FN_UNSIGNED, 32'd100, 32'd7, 0);
    add_entry("unsigned small dividend", div_msg_pkg::DIV_FN_UNSIGNED, 32'd5, 32'd9, 2);
    add_entry("unsigned max dividend", div_msg_pkg::DIV_FN_UNSIGNED, 32'hffffffff, 32'd3, 0);
    add_entry("unsigned max by max", div_msg_pkg::DIV_FN_UNSIGNED,
              32'hffffffff, 32'hffffffff, 1);
    add_entry("unsigned by one", div_msg_pkg::DIV_FN_UNSIGNED, 32'h12345678, 32'd1, 0);
    add_entry("signed pos pos", div_msg_pkg::DIV_FN_SIGNED, 32'd100, 32'd7, 3);
    add_entry("signed neg pos", div_msg_pkg::DIV_FN_SIGNED, 32'hffffff9c, 32'd7, 0);
    add_entry("signed pos neg", div_msg_pkg::DIV_FN_SIGNED, 32'd100, 32'hfffffff9, 1);
    add_entry("signed neg neg", div_msg_pkg::DIV_FN_SIGNED, 32'hffffff9c, 32'hfffffff9, 0);
    add_entry("signed min by minus one", div_msg_pkg::DIV_FN_SIGNED,
              32'h80000000, 32'hffffffff, 0);
    add_entry("unsigned div zero", div_msg_pkg::DIV_FN_UNSIGNED, 32'd1234, 32'd0, 0);
    add_entry("signed div zero pos", div_msg_pkg::DIV_FN_SIGNED, 32'd1234, 32'd0, 2);
    add_entry("signed div zero neg", div_msg_pkg::DIV_FN_SIGNED, 32'hfffffb2e, 32'd0, 0);
    add_entry("unsigned long stall", div_msg_pkg::DIV_FN_UNSIGNED, 32'd1000, 32'd33, 7);

    // random rows with random function and short stalls
    for (int k = 0; k < num_random; k++) begin
      rnd = $urandom();
      add_entry($sformatf("random %0d", k), div_msg_pkg::div_fn_e'(rnd[0]),
                $urandom(), $urandom(), int'($urandom() % 4));
    end
    table_done = 1'b1;

    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value("reset ready", 64'd1, 64'(req_rdy));
    check_value("reset valid", 64'd0, 64'(resp_val));

    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
    end

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int limit;
    wait (table_done);
    limit = num_entries * (32 + max_stall + 4) + 20;
    repeat (limit) @(posedge clk);
    $display("timeout: the divider stopped responding within %0d clock cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
src/div_msg_pkg.sv
src/div_ctrl_pkg.sv
src/int_div_ctrl.sv
src/int_div_dpath.sv
src/int_div_iterative.sv
bench/int_div_asserts.sv
bench/int_div_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = int_div_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
